//--- source/decode_pkg.sv
// shared widths, opcodes, instruction formats and packet types for the decode stage
`default_nettype none

package decode_pkg;

  localparam int XLEN       = 64;
  localparam int ILEN       = 32;
  localparam int REG_ADDR_W = 5;

  // major opcodes, instruction bits 6:2
  localparam logic [4:0] OPC_LUI      = 5'b01101;
  localparam logic [4:0] OPC_AUIPC    = 5'b00101;
  localparam logic [4:0] OPC_JAL      = 5'b11011;
  localparam logic [4:0] OPC_JALR     = 5'b11001;
  localparam logic [4:0] OPC_BRANCH   = 5'b11000;
  localparam logic [4:0] OPC_LOAD     = 5'b00000;
  localparam logic [4:0] OPC_STORE    = 5'b01000;
  localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
  localparam logic [4:0] OPC_OP_IMM_W = 5'b00110;
  localparam logic [4:0] OPC_OP       = 5'b01100;
  localparam logic [4:0] OPC_OP_W     = 5'b01110;

  // operation class seen by execute
  localparam logic [2:0] CLS_ALU    = 3'd0;
  localparam logic [2:0] CLS_ALU_W  = 3'd1;
  localparam logic [2:0] CLS_LOAD   = 3'd2;
  localparam logic [2:0] CLS_STORE  = 3'd3;
  localparam logic [2:0] CLS_BRANCH = 3'd4;
  localparam logic [2:0] CLS_JUMP   = 3'd5;
  localparam logic [2:0] CLS_NONE   = 3'd7;

  // alu codes, branches put funct3 here instead
  localparam logic [3:0] ALU_ADD  = 4'd0;
  localparam logic [3:0] ALU_SUB  = 4'd1;
  localparam logic [3:0] ALU_SLL  = 4'd2;
  localparam logic [3:0] ALU_SLT  = 4'd3;
  localparam logic [3:0] ALU_SLTU = 4'd4;
  localparam logic [3:0] ALU_XOR  = 4'd5;
  localparam logic [3:0] ALU_SRL  = 4'd6;
  localparam logic [3:0] ALU_SRA  = 4'd7;
  localparam logic [3:0] ALU_OR   = 4'd8;
  localparam logic [3:0] ALU_AND  = 4'd9;

  // second operand source
  localparam logic [1:0] OP2_REG  = 2'd0;
  localparam logic [1:0] OP2_IMM  = 2'd1;
  localparam logic [1:0] OP2_FOUR = 2'd2;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // one instruction word, read in whichever format the opcode calls for
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
  } inst_u;

  typedef struct packed {
    logic                  valid;
    logic                  is_load;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } fwd_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    inst_u           inst;
  } fetch_pkt_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;
    logic [2:0]            cls;
    logic [3:0]            alu_op;
    logic [2:0]            mem_size;
    logic                  rd_we;
    logic [REG_ADDR_W-1:0] rd;
  } issue_pkt_t;

  typedef struct packed {
    logic [2:0]            cls;
    logic [3:0]            alu_op;
    logic [2:0]            mem_size;
    logic                  rd_we;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic                  rs1_used;
    logic                  rs2_used;
    logic                  op1_is_pc;
    logic [1:0]            op2_sel;
    logic                  is_jalr;
  } decoded_t;

endpackage

`default_nettype wire

//--- source/inst_decoder.sv
// combinational RV64I decoder: class, alu code, immediate and register usage of one instruction
`timescale 1ns/10ps
`default_nettype none

module inst_decoder import decode_pkg::*; (
  input  inst_u           inst_i,
  output decoded_t        dec_o,
  output logic [XLEN-1:0] imm_o
);

  logic [4:0]            opc;
  logic [2:0]            funct3;
  logic                  alt;
  logic                  m_ext;
  logic                  rd_wr;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm_i_ext;
  logic [XLEN-1:0]       imm_s_ext;
  logic [XLEN-1:0]       imm_b_ext;
  logic [XLEN-1:0]       imm_u_ext;

  // funct3 plus bit 30 to alu code, sub only for register forms
  function automatic logic [3:0] alu_code(input logic [2:0] f3, input logic alt_bit,
                                          input logic allow_sub);
    logic [3:0] code;
    case (f3)
      3'b000:  code = (alt_bit && allow_sub) ? ALU_SUB : ALU_ADD;
      3'b001:  code = ALU_SLL;
      3'b010:  code = ALU_SLT;
      3'b011:  code = ALU_SLTU;
      3'b100:  code = ALU_XOR;
      3'b101:  code = alt_bit ? ALU_SRA : ALU_SRL;
      3'b110:  code = ALU_OR;
      default: code = ALU_AND;
    endcase
    return code;
  endfunction

  assign opc    = inst_i.r_fmt.opcode[6:2];
  assign funct3 = inst_i.r_fmt.funct3;
  assign alt    = inst_i.r_fmt.funct7[5];
  assign rd     = inst_i.r_fmt.rd;
  // mul/div share the OP opcodes, marked by funct7 bit 0
  assign m_ext  = inst_i.r_fmt.funct7[0];

  assign imm_i_ext = {{(XLEN-12){inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
  assign imm_s_ext = {{(XLEN-12){inst_i.s_fmt.imm_hi[6]}}, inst_i.s_fmt.imm_hi,
                      inst_i.s_fmt.imm_lo};
  assign imm_b_ext = {{(XLEN-12){inst_i.b_fmt.imm_12}}, inst_i.b_fmt.imm_11,
                      inst_i.b_fmt.imm_10_5, inst_i.b_fmt.imm_4_1, 1'b0};
  assign imm_u_ext = {{(XLEN-32){inst_i.u_fmt.imm[19]}}, inst_i.u_fmt.imm, 12'b0};

  always_comb begin
    dec_o           = '0;
    dec_o.cls       = CLS_NONE;
    dec_o.alu_op    = ALU_ADD;
    dec_o.rs1       = inst_i.r_fmt.rs1;
    dec_o.rs2       = inst_i.r_fmt.rs2;
    dec_o.op2_sel   = OP2_REG;
    imm_o           = '0;
    rd_wr           = 1'b0;

    case (opc)
      OPC_OP, OPC_OP_W: begin
        if (!m_ext) begin
          dec_o.cls      = (opc == OPC_OP_W) ? CLS_ALU_W : CLS_ALU;
          dec_o.alu_op   = alu_code(funct3, alt, 1'b1);
          dec_o.rs1_used = 1'b1;
          dec_o.rs2_used = 1'b1;
          rd_wr          = 1'b1;
        end
      end
      OPC_OP_IMM, OPC_OP_IMM_W: begin
        dec_o.cls      = (opc == OPC_OP_IMM_W) ? CLS_ALU_W : CLS_ALU;
        // bit 30 of the I immediate picks srai over srli
        dec_o.alu_op   = alu_code(funct3, inst_i.i_fmt.imm[10], 1'b0);
        dec_o.rs1_used = 1'b1;
        dec_o.op2_sel  = OP2_IMM;
        imm_o          = imm_i_ext;
        rd_wr          = 1'b1;
      end
      OPC_LOAD: begin
        dec_o.cls      = CLS_LOAD;
        dec_o.mem_size = funct3;
        dec_o.rs1_used = 1'b1;
        dec_o.op2_sel  = OP2_IMM;
        imm_o          = imm_i_ext;
        rd_wr          = 1'b1;
      end
      OPC_STORE: begin
        dec_o.cls      = CLS_STORE;
        dec_o.mem_size = funct3;
        dec_o.rs1_used = 1'b1;
        dec_o.rs2_used = 1'b1;
        imm_o          = imm_s_ext;
      end
      OPC_BRANCH: begin
        dec_o.cls      = CLS_BRANCH;
        dec_o.alu_op   = {1'b0, funct3};
        dec_o.rs1_used = 1'b1;
        dec_o.rs2_used = 1'b1;
        imm_o          = imm_b_ext;
      end
      OPC_LUI, OPC_AUIPC: begin
        dec_o.cls       = CLS_ALU;
        dec_o.op1_is_pc = (opc == OPC_AUIPC);
        dec_o.op2_sel   = OP2_IMM;
        imm_o           = imm_u_ext;
        rd_wr           = 1'b1;
      end
      OPC_JAL: begin
        dec_o.cls       = CLS_JUMP;
        dec_o.op1_is_pc = 1'b1;
        dec_o.op2_sel   = OP2_FOUR;
        rd_wr           = 1'b1;
      end
      OPC_JALR: begin
        dec_o.cls       = CLS_JUMP;
        dec_o.rs1_used  = 1'b1;
        dec_o.op1_is_pc = 1'b1;
        dec_o.op2_sel   = OP2_FOUR;
        dec_o.is_jalr   = 1'b1;
        imm_o           = imm_i_ext;
        rd_wr           = 1'b1;
      end
      default: begin
      end
    endcase

    // writes to x0 are dropped here
    dec_o.rd_we = rd_wr && (rd != '0);
    dec_o.rd    = dec_o.rd_we ? rd : '0;
  end

  always_comb begin
    assert (!dec_o.rs2_used || dec_o.rs1_used)
      else $error("inst_decoder: rs2 used without rs1");
  end

endmodule

`default_nettype wire

//--- source/operand_bypass.sv
// operand selection for decode with ex/mem forwarding and the load-use stall
`timescale 1ns/10ps
`default_nettype none

module operand_bypass import decode_pkg::*; (
  input  decoded_t              dec_i,
  input  logic [XLEN-1:0]       imm_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic [XLEN-1:0]       rs1_data_i,
  input  logic [XLEN-1:0]       rs2_data_i,
  input  fwd_t                  ex_fwd_i,
  input  fwd_t                  mem_fwd_i,
  output logic [REG_ADDR_W-1:0] rs1_addr_o,
  output logic [REG_ADDR_W-1:0] rs2_addr_o,
  output logic [XLEN-1:0]       op1_o,
  output logic [XLEN-1:0]       op2_o,
  output logic [XLEN-1:0]       jalr_target_o,
  output logic                  stall_o
);

  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] jalr_sum;
  logic            ex_load_hit;

  // ex wins over mem, x0 always takes the regfile value
  function automatic logic [XLEN-1:0] fwd_value(input logic [REG_ADDR_W-1:0] addr,
                                                input logic [XLEN-1:0] rf_data,
                                                input fwd_t ex, input fwd_t mem);
    logic [XLEN-1:0] val;
    if (addr == '0) begin
      val = rf_data;
    end else if (ex.valid && (ex.rd == addr)) begin
      val = ex.data;
    end else if (mem.valid && (mem.rd == addr)) begin
      val = mem.data;
    end else begin
      val = rf_data;
    end
    return val;
  endfunction

  // unused sources read x0
  assign rs1_addr_o = dec_i.rs1_used ? dec_i.rs1 : '0;
  assign rs2_addr_o = dec_i.rs2_used ? dec_i.rs2 : '0;

  assign rs1_val = fwd_value(rs1_addr_o, rs1_data_i, ex_fwd_i, mem_fwd_i);
  assign rs2_val = fwd_value(rs2_addr_o, rs2_data_i, ex_fwd_i, mem_fwd_i);

  always_comb begin
    if (dec_i.op1_is_pc) begin
      op1_o = pc_i;
    end else if (dec_i.rs1_used) begin
      op1_o = rs1_val;
    end else begin
      op1_o = '0;
    end
  end

  always_comb begin
    case (dec_i.op2_sel)
      OP2_REG:  op2_o = rs2_val;
      OP2_IMM:  op2_o = imm_i;
      OP2_FOUR: op2_o = 64'd4;
      default:  op2_o = '0;
    endcase
  end

  assign jalr_sum      = rs1_val + imm_i;
  assign jalr_target_o = {jalr_sum[XLEN-1:1], 1'b0};

  // load in ex has no data yet, hold the consumer one cycle
  assign ex_load_hit = ex_fwd_i.valid && ex_fwd_i.is_load && (ex_fwd_i.rd != '0);
  assign stall_o     = ex_load_hit &&
                       ((ex_fwd_i.rd == rs1_addr_o) || (ex_fwd_i.rd == rs2_addr_o));

  always_comb begin
    assert (!stall_o || dec_i.rs1_used || dec_i.rs2_used)
      else $error("operand_bypass: stall with no source used");
  end

endmodule

`default_nettype wire

//--- source/decode_issue_reg.sv
// issue packet register between decode and execute with handshake and jalr redirect
`timescale 1ns/10ps
`default_nettype none

module decode_issue_reg import decode_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            in_valid_i,
  input  decoded_t        dec_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] op1_i,
  input  logic [XLEN-1:0] op2_i,
  input  logic [XLEN-1:0] jalr_target_i,
  input  logic            stall_i,
  input  logic            out_ready_i,
  output logic            in_ready_o,
  output issue_pkt_t      out_pkt_o,
  output logic            out_valid_o,
  output logic            redirect_o,
  output logic [XLEN-1:0] redirect_pc_o
);

  logic accept;
  logic keep;

  assign in_ready_o = (!out_valid_o || out_ready_i) && !stall_i;
  assign accept     = in_valid_i && in_ready_o;
  // the word taken while redirect is up is from the old path
  assign keep       = accept && !redirect_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
      redirect_o  <= 1'b0;
    end else begin
      redirect_o <= keep && dec_i.is_jalr;
      if (keep) begin
        out_valid_o <= 1'b1;
      end else if (out_ready_i) begin
        out_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (keep) begin
      out_pkt_o.pc       <= pc_i;
      out_pkt_o.op1      <= op1_i;
      out_pkt_o.op2      <= op2_i;
      out_pkt_o.cls      <= dec_i.cls;
      out_pkt_o.alu_op   <= dec_i.alu_op;
      out_pkt_o.mem_size <= dec_i.mem_size;
      out_pkt_o.rd_we    <= dec_i.rd_we;
      out_pkt_o.rd       <= dec_i.rd;
    end
  end

  // target stays put until the next jalr
  always_ff @(posedge clk_i) begin
    if (keep && dec_i.is_jalr) begin
      redirect_pc_o <= jalr_target_i;
    end
  end

  a_hold_pkt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_pkt_o))
    else $error("decode_issue_reg: packet changed under back-pressure");

  a_redirect_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    redirect_o |=> !redirect_o)
    else $error("decode_issue_reg: redirect held two cycles");

endmodule

`default_nettype wire

//--- source/decode_stage.sv
// top of the decode stage, decoder and bypass feeding the issue register
`timescale 1ns/10ps
`default_nettype none

module decode_stage import decode_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  fetch_pkt_t            in_pkt_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  output logic [REG_ADDR_W-1:0] rs1_addr_o,
  output logic [REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [XLEN-1:0]       rs1_data_i,
  input  logic [XLEN-1:0]       rs2_data_i,
  input  fwd_t                  ex_fwd_i,
  input  fwd_t                  mem_fwd_i,
  output issue_pkt_t            out_pkt_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  redirect_o,
  output logic [XLEN-1:0]       redirect_pc_o
);

  decoded_t        dec;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  logic [XLEN-1:0] jalr_target;
  logic            stall;

  inst_decoder inst_decoder_i (
    .inst_i (in_pkt_i.inst),
    .dec_o  (dec),
    .imm_o  (imm)
  );

  operand_bypass operand_bypass_i (
    .dec_i         (dec),
    .imm_i         (imm),
    .pc_i          (in_pkt_i.pc),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .ex_fwd_i      (ex_fwd_i),
    .mem_fwd_i     (mem_fwd_i),
    .rs1_addr_o    (rs1_addr_o),
    .rs2_addr_o    (rs2_addr_o),
    .op1_o         (op1),
    .op2_o         (op2),
    .jalr_target_o (jalr_target),
    .stall_o       (stall)
  );

  decode_issue_reg decode_issue_reg_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .in_valid_i    (in_valid_i),
    .dec_i         (dec),
    .pc_i          (in_pkt_i.pc),
    .op1_i         (op1),
    .op2_i         (op2),
    .jalr_target_i (jalr_target),
    .stall_i       (stall),
    .out_ready_i   (out_ready_i),
    .in_ready_o    (in_ready_o),
    .out_pkt_o     (out_pkt_o),
    .out_valid_o   (out_valid_o),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
  );

endmodule

`default_nettype wire

//--- sim/tb_decode_checks.sv
// reference model and assertions for the decode stage testbench, bound to the DUT ports
`timescale 1ns/10ps
`default_nettype none

module tb_decode_checks import decode_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  fetch_pkt_t      in_pkt_i,
  input  logic            in_valid_i,
  input  logic            in_ready_o,
  input  logic [4:0]      rs1_addr_o,
  input  logic [4:0]      rs2_addr_o,
  input  fwd_t            ex_fwd_i,
  input  fwd_t            mem_fwd_i,
  input  issue_pkt_t      out_pkt_o,
  input  logic            out_valid_o,
  input  logic            out_ready_i,
  input  logic            redirect_o,
  input  logic [XLEN-1:0] redirect_pc_o,
  input  logic [2:0]      test_id_i,
  output logic            fail_o,
  output int              pending_o
);

  issue_pkt_t      exp_q[$];
  issue_pkt_t      exp_pkt;
  issue_pkt_t      exp_head;
  logic            exp_stall;
  logic            exp_jalr;
  logic [XLEN-1:0] exp_target;
  logic [4:0]      exp_rs1_addr;
  logic [4:0]      exp_rs2_addr;
  logic [XLEN-1:0] target_q;
  logic            keep;
  logic            error_seen = 1'b0;

  assign fail_o = error_seen;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1:    return "reset";
      3'd2:    return "random_decode";
      3'd3:    return "forwarding";
      3'd4:    return "load_use";
      3'd5:    return "jumps";
      3'd6:    return "back_pressure";
      default: return "idle";
    endcase
  endfunction

  task automatic report(input string msg);
    $display("%s", msg);
    error_seen = 1'b1;
  endtask

  // every byte of a register holds its number
  function automatic logic [XLEN-1:0] rf_val(input logic [4:0] r);
    return {8{3'b000, r}};
  endfunction

  function automatic logic [XLEN-1:0] fwd_val(input logic [4:0] r, input fwd_t ex,
                                              input fwd_t mem);
    if (r == 5'd0) return rf_val(r);
    if (ex.valid && ex.rd == r) return ex.data;
    if (mem.valid && mem.rd == r) return mem.data;
    return rf_val(r);
  endfunction

  function automatic logic [3:0] alu_of(input logic [2:0] f3, input logic bit30,
                                        input logic reg_form);
    case (f3)
      3'b000:  return (bit30 && reg_form) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return bit30 ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    logic [31:0]     w;
    logic [4:0]      opc;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [2:0]      f3;
    logic            u1;
    logic            u2;
    logic            we;
    logic [XLEN-1:0] i_imm;
    logic [XLEN-1:0] s_imm;
    logic [XLEN-1:0] u_imm;
    logic [XLEN-1:0] rs1v;
    logic [XLEN-1:0] rs2v;
    w     = in_pkt_i.inst;
    opc   = w[6:2];
    rd    = w[11:7];
    f3    = w[14:12];
    rs1   = w[19:15];
    rs2   = w[24:20];
    i_imm = {{52{w[31]}}, w[31:20]};
    s_imm = {{52{w[31]}}, w[31:25], w[11:7]};
    u_imm = {{32{w[31]}}, w[31:12], 12'h000};
    rs1v  = fwd_val(rs1, ex_fwd_i, mem_fwd_i);
    rs2v  = fwd_val(rs2, ex_fwd_i, mem_fwd_i);
    u1 = 1'b0;
    u2 = 1'b0;
    we = 1'b0;
    exp_jalr    = 1'b0;
    exp_pkt     = '0;
    exp_pkt.pc  = in_pkt_i.pc;
    exp_pkt.cls = CLS_NONE;
    case (opc)
      OPC_OP, OPC_OP_W: begin
        // funct7 bit 0 marks the dropped M extension
        if (!w[25]) begin
          exp_pkt.cls    = (opc == OPC_OP_W) ? CLS_ALU_W : CLS_ALU;
          exp_pkt.alu_op = alu_of(f3, w[30], 1'b1);
          u1 = 1'b1;
          u2 = 1'b1;
          we = 1'b1;
          exp_pkt.op1 = rs1v;
          exp_pkt.op2 = rs2v;
        end
      end
      OPC_OP_IMM, OPC_OP_IMM_W: begin
        exp_pkt.cls    = (opc == OPC_OP_IMM_W) ? CLS_ALU_W : CLS_ALU;
        exp_pkt.alu_op = alu_of(f3, w[30], 1'b0);
        u1 = 1'b1;
        we = 1'b1;
        exp_pkt.op1 = rs1v;
        exp_pkt.op2 = i_imm;
      end
      OPC_LOAD: begin
        exp_pkt.cls      = CLS_LOAD;
        exp_pkt.mem_size = f3;
        u1 = 1'b1;
        we = 1'b1;
        exp_pkt.op1 = rs1v;
        exp_pkt.op2 = i_imm;
      end
      OPC_STORE: begin
        exp_pkt.cls      = CLS_STORE;
        exp_pkt.mem_size = f3;
        u1 = 1'b1;
        u2 = 1'b1;
        exp_pkt.op1 = rs1v;
        exp_pkt.op2 = rs2v;
      end
      OPC_BRANCH: begin
        exp_pkt.cls    = CLS_BRANCH;
        exp_pkt.alu_op = {1'b0, f3};
        u1 = 1'b1;
        u2 = 1'b1;
        exp_pkt.op1 = rs1v;
        exp_pkt.op2 = rs2v;
      end
      OPC_LUI, OPC_AUIPC: begin
        exp_pkt.cls = CLS_ALU;
        we = 1'b1;
        exp_pkt.op1 = (opc == OPC_AUIPC) ? in_pkt_i.pc : '0;
        exp_pkt.op2 = u_imm;
      end
      OPC_JAL, OPC_JALR: begin
        exp_pkt.cls = CLS_JUMP;
        u1 = (opc == OPC_JALR);
        we = 1'b1;
        exp_jalr    = (opc == OPC_JALR);
        exp_pkt.op1 = in_pkt_i.pc;
        exp_pkt.op2 = 64'd4;
      end
      default: begin
      end
    endcase
    exp_pkt.rd_we = we && (rd != 5'd0);
    exp_pkt.rd    = exp_pkt.rd_we ? rd : 5'd0;
    exp_rs1_addr  = u1 ? rs1 : 5'd0;
    exp_rs2_addr  = u2 ? rs2 : 5'd0;
    exp_target    = (rs1v + i_imm) & ~64'h1;
    exp_stall     = ex_fwd_i.valid && ex_fwd_i.is_load && (ex_fwd_i.rd != 5'd0) &&
                    ((u1 && ex_fwd_i.rd == rs1) || (u2 && ex_fwd_i.rd == rs2));
  end

  // a word taken during the redirect cycle is squashed
  assign keep = in_valid_i && in_ready_o && !redirect_o;

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      exp_q.delete();
    end else begin
      if (out_valid_o && out_ready_i && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      if (keep) begin
        exp_q.push_back(exp_pkt);
      end
      if (keep && exp_jalr) begin
        target_q <= exp_target;
      end
    end
    exp_head  = (exp_q.size() != 0) ? exp_q[0] : '0;
    pending_o = exp_q.size();
  end

  a_reset_quiet: assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_o && !redirect_o)
    else report("out_valid_o or redirect_o high right after reset");

  a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i) keep |=> out_valid_o)
    else report("accepted instruction did not appear one cycle later");

  a_first: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(out_valid_o) |-> $past(keep))
    else report("out_valid_o rose without an accepted instruction");

  a_no_extra: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o |-> pending_o != 0)
    else report("packet on the execute side with none expected");

  // held packets are compared too, so a change under back-pressure shows up
  a_packet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o |-> out_pkt_o == exp_head)
    else report($sformatf("MISMATCH %s expected %h actual %h", test_name($sampled(test_id_i)),
                          $sampled(exp_head), $sampled(out_pkt_o)));

  a_rf_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    {rs1_addr_o, rs2_addr_o} == {exp_rs1_addr, exp_rs2_addr})
    else report($sformatf("MISMATCH %s expected %h actual %h", test_name($sampled(test_id_i)),
                          {$sampled(exp_rs1_addr), $sampled(exp_rs2_addr)},
                          {$sampled(rs1_addr_o), $sampled(rs2_addr_o)}));

  a_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_valid_i && exp_stall |-> !in_ready_o)
    else report("in_ready_o high during a load-use hazard");

  a_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (!out_valid_o || out_ready_i) && !exp_stall |-> in_ready_o)
    else report("in_ready_o low with room and no hazard");

  a_redirect_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    keep && exp_jalr |=> redirect_o)
    else report("no redirect after an accepted JALR");

  a_redirect_only: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    redirect_o |-> $past(keep && exp_jalr))
    else report("redirect_o high without an accepted JALR");

  a_redirect_pc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    redirect_o |-> redirect_pc_o == target_q)
    else report($sformatf("MISMATCH %s expected %h actual %h", test_name($sampled(test_id_i)),
                          $sampled(target_q), $sampled(redirect_pc_o)));

endmodule

`default_nettype wire

//--- sim/tb_decode_stage.sv
// testbench top for the decode stage: clock, reset, stimulus, register file and forwarding
`timescale 1ns/10ps
`default_nettype none

module tb_decode_stage import decode_pkg::*; ();

  localparam int TIMEOUT = 40;

  logic                  clk_i = 1'b0;
  logic                  rst_n_i;
  fetch_pkt_t            in_pkt_i;
  logic                  in_valid_i;
  logic                  in_ready_o;
  logic [REG_ADDR_W-1:0] rs1_addr_o;
  logic [REG_ADDR_W-1:0] rs2_addr_o;
  logic [XLEN-1:0]       rs1_data_i;
  logic [XLEN-1:0]       rs2_data_i;
  fwd_t                  ex_fwd_i;
  fwd_t                  mem_fwd_i;
  issue_pkt_t            out_pkt_o;
  logic                  out_valid_o;
  logic                  out_ready_i = 1'b1;
  logic                  redirect_o;
  logic [XLEN-1:0]       redirect_pc_o;
  logic [2:0]            test_id;
  logic                  check_fail;
  int                    pending;
  logic [31:0]           seed;
  logic [31:0]           ready_seed = 32'h123c;
  logic                  ready_random;

  always #4 clk_i = ~clk_i;

  assign rs1_data_i = 64'(rs1_addr_o) * 64'h0101_0101_0101_0101;
  assign rs2_data_i = 64'(rs2_addr_o) * 64'h0101_0101_0101_0101;

  decode_stage decode_stage_i (.*);

  tb_decode_checks checks_i (
    .*,
    .test_id_i (test_id),
    .fail_o    (check_fail),
    .pending_o (pending)
  );

  always @(posedge check_fail) begin
    $display("Verification failed");
    $fatal(1, "assertion check failed");
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = lcg(seed);
    return seed;
  endfunction

  // execute side randomly stalls when enabled
  always @(posedge clk_i) begin
    #1;
    if (ready_random) begin
      ready_seed  = lcg(ready_seed);
      out_ready_i = ready_seed[16];
    end else begin
      out_ready_i = 1'b1;
    end
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] opc);
    return {f7, rs2, rs1, f3, rd, opc, 2'b11};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] opc);
    return {imm, rs1, f3, rd, opc, 2'b11};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE, 2'b11};
  endfunction

  // imm holds offset bits 12:1
  function automatic logic [31:0] b_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11], imm[9:4], rs2, rs1, f3, imm[3:0], imm[10], OPC_BRANCH, 2'b11};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [4:0] opc);
    return {imm, rd, opc, 2'b11};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "run aborted");
  endtask

  task automatic issue(input logic [XLEN-1:0] pc, input logic [31:0] inst);
    int   cycles;
    logic taken;
    cycles        = 0;
    taken         = 1'b0;
    in_pkt_i.pc   = pc;
    in_pkt_i.inst = inst;
    in_valid_i    = 1'b1;
    while (!taken) begin
      @(negedge clk_i);
      taken = in_ready_o;
      @(posedge clk_i);
      #1;
      cycles++;
      if (!taken && cycles > TIMEOUT) abort_run("timeout waiting for in_ready_o");
    end
    in_valid_i = 1'b0;
  endtask

  function automatic logic [XLEN-1:0] rand_pc();
    return {next_rand(), next_rand() & 32'hffff_fffc};
  endfunction

  task automatic random_ops(input int n);
    logic [31:0] w;
    logic [4:0]  rd;
    logic [31:0] inst;
    int          kind;
    for (int i = 0; i < n; i++) begin
      w    = next_rand();
      kind = int'(next_rand() % 32'd6);
      rd   = (i % 8 == 0) ? 5'd0 : w[4:0];
      case (kind)
        0: inst = r_type({1'b0, w[18], 5'b0}, w[14:10], w[9:5], w[17:15], rd, OPC_OP);
        1: inst = i_type(w[30:19], w[9:5], w[17:15], rd, OPC_OP_IMM);
        2: inst = w[31] ? r_type({1'b0, w[18], 5'b0}, w[14:10], w[9:5], w[17:15], rd, OPC_OP_W)
                        : i_type(w[30:19], w[9:5], w[17:15], rd, OPC_OP_IMM_W);
        3: inst = i_type(w[30:19], w[9:5], w[17:15], rd, OPC_LOAD);
        4: inst = s_type(w[30:19], w[14:10], w[9:5], w[17:15]);
        default: inst = b_type(w[30:19], w[14:10], w[9:5], w[17:15]);
      endcase
      issue(rand_pc(), inst);
    end
  endtask

  task automatic drain();
    int cycles;
    cycles = 0;
    while (pending != 0 || out_valid_o) begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles > TIMEOUT) abort_run("timeout draining the issue register");
    end
  endtask

  initial begin
    logic [XLEN-1:0] pc;
    seed          = 32'h123c;
    ready_random  = 1'b0;
    rst_n_i       = 1'b0;
    in_valid_i    = 1'b0;
    in_pkt_i.pc   = '0;
    in_pkt_i.inst = 32'h0000_0013;
    ex_fwd_i      = '0;
    mem_fwd_i     = '0;
    test_id       = 3'd1;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    issue(rand_pc(), r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP));

    test_id = 3'd2;
    random_ops(60);

    test_id = 3'd3;
    ex_fwd_i  = '{valid: 1'b1, is_load: 1'b0, rd: 5'd5, data: 64'hdead_beef_0000_1111};
    mem_fwd_i = '{valid: 1'b1, is_load: 1'b0, rd: 5'd5, data: 64'h5555_aaaa_5555_aaaa};
    issue(rand_pc(), r_type(7'h00, 5'd5, 5'd5, 3'b000, 5'd1, OPC_OP));
    ex_fwd_i.valid = 1'b0;
    issue(rand_pc(), r_type(7'h20, 5'd5, 5'd5, 3'b000, 5'd1, OPC_OP));
    ex_fwd_i  = '{valid: 1'b1, is_load: 1'b0, rd: 5'd0, data: 64'h1234};
    mem_fwd_i = '{valid: 1'b1, is_load: 1'b0, rd: 5'd0, data: 64'h5678};
    issue(rand_pc(), r_type(7'h00, 5'd0, 5'd0, 3'b110, 5'd2, OPC_OP));
    mem_fwd_i = '0;

    // load in ex feeding rs1 holds the consumer
    test_id = 3'd4;
    ex_fwd_i      = '{valid: 1'b1, is_load: 1'b1, rd: 5'd7, data: 64'h0};
    pc            = rand_pc();
    in_pkt_i.pc   = pc;
    in_pkt_i.inst = r_type(7'h00, 5'd3, 5'd7, 3'b000, 5'd2, OPC_OP);
    in_valid_i    = 1'b1;
    repeat (3) @(posedge clk_i);
    #1;
    ex_fwd_i = '{valid: 1'b1, is_load: 1'b0, rd: 5'd7, data: 64'hcafe_f00d_0bad_0001};
    issue(pc, r_type(7'h00, 5'd3, 5'd7, 3'b000, 5'd2, OPC_OP));
    ex_fwd_i = '0;

    test_id = 3'd5;
    mem_fwd_i = '{valid: 1'b1, is_load: 1'b0, rd: 5'd9, data: 64'h0000_0040_0000_1001};
    issue(rand_pc(), u_type(20'(next_rand() >> 12), 5'd3, OPC_LUI));
    issue(rand_pc(), u_type(20'(next_rand() >> 12), 5'd4, OPC_AUIPC));
    issue(rand_pc(), u_type(20'(next_rand() >> 12), 5'd1, OPC_JAL));
    issue(rand_pc(), i_type(12'h7f3, 5'd9, 3'b000, 5'd1, OPC_JALR));
    // fall-through word from the old path, dropped by the redirect
    issue(rand_pc(), u_type(20'h12345, 5'd6, OPC_LUI));
    issue(rand_pc(), i_type(12'h801, 5'd4, 3'b000, 5'd0, OPC_JALR));
    @(posedge clk_i);
    #1;
    mem_fwd_i = '0;

    test_id = 3'd6;
    ready_random = 1'b1;
    random_ops(40);
    ready_random = 1'b0;
    drain();

    if (pending != 0 || check_fail) begin
      $display("Verification failed");
      $fatal(1, "packets left unissued");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- decode_stage.f
source/decode_pkg.sv
source/inst_decoder.sv
source/operand_bypass.sv
source/decode_issue_reg.sv
source/decode_stage.sv
sim/tb_decode_checks.sv
sim/tb_decode_stage.sv

//--- Makefile
# Verilator flow for the decode stage: lint, simulate, clean

VERILATOR ?= verilator
FLIST     ?= decode_stage.f
TOP       ?= tb_decode_stage
LINT_TOP  ?= decode_stage
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_STR  ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(LINT_TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
